//--- logic/rv_core_pkg.sv
package rv_core_pkg;

  // major opcodes of the supported subset.
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  // one instruction word, three views.
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
  } insn_t;

  typedef struct packed {
    logic [31:0] pc;
    insn_t       insn;
  } queue_entry_t;

  typedef struct packed {
    logic        wen;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
  } mem_req_t;

  // retirement record, rvfi style.
  typedef struct packed {
    logic [31:0] order;
    logic [31:0] insn;
    logic        trap;
    logic [4:0]  rd_addr;
    logic [31:0] rd_wdata;
    logic [31:0] pc_rdata;
    logic [31:0] pc_wdata;
    logic [31:0] mem_addr;
    logic [3:0]  mem_rmask;
    logic [3:0]  mem_wmask;
    logic [31:0] mem_rdata;
    logic [31:0] mem_wdata;
  } retire_t;

endpackage

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter logic [31:0] RESET_PC    = 32'h0000_0000,
  parameter int          QUEUE_DEPTH = 4
) (
  input  logic                         clock,
  input  logic                         rst_n_i,
  input  rv_core_pkg::insn_t           imem_rdata_i,
  input  logic [$clog2(QUEUE_DEPTH):0] free_count_i,
  output logic                         imem_valid_o,
  output logic [31:0]                  imem_addr_o,
  output logic                         push_valid_o,
  output rv_core_pkg::queue_entry_t    push_entry_o
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

  logic             run_q;      // set one cycle after reset release.
  logic [31:0]      pc_q;       // next address to request.
  logic [31:0]      req_pc_q;   // address of the word now returning.
  logic             rsp_q;      // read data valid on imem_rdata_i.
  logic [CNT_W-1:0] inflight_q; // requests not yet pushed.

  // only ask when the queue can take every word still on its way
  assign imem_valid_o = run_q && (free_count_i > inflight_q);
  assign imem_addr_o  = pc_q;

  assign push_valid_o = rsp_q;
  assign push_entry_o = '{pc: req_pc_q, insn: imem_rdata_i};

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      run_q      <= 1'b0;
      pc_q       <= RESET_PC;
      rsp_q      <= 1'b0;
      inflight_q <= '0;
    end else begin
      run_q <= 1'b1;
      rsp_q <= imem_valid_o;
      if (imem_valid_o) begin
        pc_q <= pc_q + 32'd4; // sequential stream.
      end
      case ({imem_valid_o, rsp_q})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (imem_valid_o) begin
      req_pc_q <= pc_q; // pairs with next cycle's data.
    end
  end

endmodule

//--- logic/insn_queue.sv
`timescale 1ns/1ps

module insn_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                         clock,
  input  logic                         rst_n_i,
  input  logic                         push_valid_i,
  input  rv_core_pkg::queue_entry_t    push_entry_i,
  input  logic                         pop_ready_i,
  output logic                         pop_valid_o,
  output rv_core_pkg::queue_entry_t    head_entry_o,
  output logic [$clog2(QUEUE_DEPTH):0] free_count_o
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  rv_core_pkg::queue_entry_t mem_q [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop;

  assign pop_valid_o  = (count_q != '0);
  assign head_entry_o = mem_q[rd_ptr_q];
  assign free_count_o = CNT_W'(QUEUE_DEPTH) - count_q;
  assign pop          = pop_valid_o && pop_ready_i;

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_valid_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1; // wraps, depth is a power of two.
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_valid_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q; // both or neither.
      endcase
    end
  end

  // fetch never pushes into a full queue
  always_ff @(posedge clock) begin
    if (push_valid_i) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic                      clock,
  input  logic                      rst_n_i,
  input  logic                      pop_valid_i,
  input  rv_core_pkg::queue_entry_t head_entry_i,
  input  logic                      mem_done_i,
  input  logic [31:0]               mem_rdata_i,
  output logic                      pop_ready_o,
  output logic                      mem_valid_o,
  output rv_core_pkg::mem_req_t     mem_req_o,
  output logic                      retire_valid_o,
  output rv_core_pkg::retire_t      retire_o
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_MEM    = 2'd1;
  localparam logic [1:0] ST_RETIRE = 2'd2;

  logic [1:0]  state_q;
  logic [31:0] order_q;
  logic        mem_valid_q;
  logic [31:0] regs_q [1:31]; // x0 is not stored.

  rv_core_pkg::insn_t    insn;
  rv_core_pkg::mem_req_t req_q;
  rv_core_pkg::retire_t  rec_d;
  rv_core_pkg::retire_t  rec_q;

  logic        pop;
  logic        mem_fin;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic        legal;
  logic        is_mem;
  logic        is_load;
  logic [31:0] alu_res;
  logic [31:0] mem_addr;

  assign pop_ready_o = (state_q == ST_IDLE);
  assign pop         = pop_valid_i && pop_ready_o;
  assign insn        = head_entry_i.insn;

  // done only counts once the start pulse is over
  assign mem_fin = (state_q == ST_MEM) && mem_done_i && !mem_valid_q;

  assign rs1_val = (insn.r_fmt.rs1 == 5'd0) ? 32'd0 : regs_q[insn.r_fmt.rs1];
  assign rs2_val = (insn.r_fmt.rs2 == 5'd0) ? 32'd0 : regs_q[insn.r_fmt.rs2];
  assign imm_i   = {{20{insn.i_fmt.imm11_0[11]}}, insn.i_fmt.imm11_0};
  assign imm_s   = {{20{insn.s_fmt.imm11_5[6]}}, insn.s_fmt.imm11_5, insn.s_fmt.imm4_0};

  always_comb begin
    legal    = 1'b0;
    is_mem   = 1'b0;
    is_load  = 1'b0;
    alu_res  = 32'd0;
    mem_addr = 32'd0;
    case (insn.r_fmt.opcode)
      rv_core_pkg::OPC_OP: begin
        if (insn.r_fmt.funct3 == 3'b000 && insn.r_fmt.funct7 == 7'b0000000) begin
          legal   = 1'b1;
          alu_res = rs1_val + rs2_val; // add.
        end else if (insn.r_fmt.funct3 == 3'b000 && insn.r_fmt.funct7 == 7'b0100000) begin
          legal   = 1'b1;
          alu_res = rs1_val - rs2_val; // sub.
        end
      end
      rv_core_pkg::OPC_OP_IMM: begin
        if (insn.i_fmt.funct3 == 3'b000) begin
          legal   = 1'b1;
          alu_res = rs1_val + imm_i; // addi.
        end
      end
      rv_core_pkg::OPC_LUI: begin
        legal   = 1'b1;
        alu_res = {insn[31:12], 12'd0}; // u-type immediate sits in the top bits.
      end
      rv_core_pkg::OPC_LOAD: begin
        if (insn.i_fmt.funct3 == 3'b010) begin
          legal    = 1'b1;
          is_mem   = 1'b1;
          is_load  = 1'b1;
          mem_addr = rs1_val + imm_i; // lw.
        end
      end
      rv_core_pkg::OPC_STORE: begin
        if (insn.s_fmt.funct3 == 3'b010) begin
          legal    = 1'b1;
          is_mem   = 1'b1;
          mem_addr = rs1_val + imm_s; // sw.
        end
      end
      default: legal = 1'b0; // retires as a trap.
    endcase
  end

  // record as far as it is known at the pop
  always_comb begin
    rec_d          = '0;
    rec_d.order    = order_q;
    rec_d.insn     = insn;
    rec_d.trap     = !legal;
    rec_d.pc_rdata = head_entry_i.pc;
    rec_d.pc_wdata = head_entry_i.pc + 32'd4;
    if (legal && !is_mem) begin
      rec_d.rd_addr  = insn.r_fmt.rd;
      rec_d.rd_wdata = (insn.r_fmt.rd == 5'd0) ? 32'd0 : alu_res;
    end
    if (is_load) begin
      rec_d.rd_addr   = insn.i_fmt.rd;
      rec_d.mem_addr  = mem_addr;
      rec_d.mem_rmask = 4'b1111;
    end else if (is_mem) begin
      rec_d.mem_addr  = mem_addr;
      rec_d.mem_wmask = 4'b1111;
      rec_d.mem_wdata = rs2_val;
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      mem_valid_q <= 1'b0;
      order_q     <= 32'd0;
    end else begin
      mem_valid_q <= pop && is_mem; // single cycle start.
      case (state_q)
        ST_IDLE: begin
          if (pop) begin
            state_q <= is_mem ? ST_MEM : ST_RETIRE;
          end
        end
        ST_MEM: begin
          if (mem_fin) begin
            state_q <= ST_RETIRE;
          end
        end
        ST_RETIRE: begin
          state_q <= ST_IDLE;
          order_q <= order_q + 32'd1;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (pop) begin
      rec_q <= rec_d;
      req_q <= '{wen: !is_load, addr: mem_addr, wdata: rs2_val, strb: 4'b1111};
    end else if (mem_fin && rec_q.mem_rmask != 4'b0000) begin
      rec_q.mem_rdata <= mem_rdata_i; // load data.
      if (rec_q.rd_addr != 5'd0) begin
        rec_q.rd_wdata <= mem_rdata_i;
      end
    end
  end

  // writeback at the end of the retire cycle
  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= 32'd0;
      end
    end else if (state_q == ST_RETIRE && rec_q.rd_addr != 5'd0) begin
      regs_q[rec_q.rd_addr] <= rec_q.rd_wdata;
    end
  end

  assign mem_valid_o    = mem_valid_q;
  assign mem_req_o      = req_q;
  assign retire_valid_o = (state_q == ST_RETIRE);
  assign retire_o       = rec_q;

endmodule

//--- logic/core_top.sv
`timescale 1ns/1ps

module core_top #(
  parameter int          QUEUE_DEPTH = 4,
  parameter logic [31:0] RESET_PC    = 32'h0000_0000
) (
  input  logic                  clock,
  input  logic                  rst_n_i,
  input  rv_core_pkg::insn_t    imem_rdata_i,
  input  logic                  mem_done_i,
  input  logic [31:0]           mem_rdata_i,
  output logic                  imem_valid_o,
  output logic [31:0]           imem_addr_o,
  output logic                  mem_valid_o,
  output rv_core_pkg::mem_req_t mem_req_o,
  output logic                  retire_valid_o,
  output rv_core_pkg::retire_t  retire_o
);

  localparam int CNT_W = $clog2(QUEUE_DEPTH) + 1;

  logic                      push_valid;
  rv_core_pkg::queue_entry_t push_entry;
  logic [CNT_W-1:0]          free_count;
  logic                      pop_valid;
  logic                      pop_ready;
  rv_core_pkg::queue_entry_t head_entry;

  fetch_unit #(
    .RESET_PC    (RESET_PC),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) fetch_unit_i (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .imem_rdata_i (imem_rdata_i),
    .free_count_i (free_count),
    .imem_valid_o (imem_valid_o),
    .imem_addr_o  (imem_addr_o),
    .push_valid_o (push_valid),
    .push_entry_o (push_entry)
  );

  insn_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) insn_queue_i (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .push_valid_i (push_valid),
    .push_entry_i (push_entry),
    .pop_ready_i  (pop_ready),
    .pop_valid_o  (pop_valid),
    .head_entry_o (head_entry),
    .free_count_o (free_count)
  );

  exec_unit exec_unit_i (
    .clock          (clock),
    .rst_n_i        (rst_n_i),
    .pop_valid_i    (pop_valid),
    .head_entry_i   (head_entry),
    .mem_done_i     (mem_done_i),
    .mem_rdata_i    (mem_rdata_i),
    .pop_ready_o    (pop_ready),
    .mem_valid_o    (mem_valid_o),
    .mem_req_o      (mem_req_o),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

endmodule

//--- tb/core_top_assert.sv
`timescale 1ns/1ps

module core_top_assert (
  input logic                 clock,
  input logic                 rst_n_i,
  input logic                 imem_valid_i,
  input logic                 mem_valid_i,
  input logic                 mem_done_i,
  input logic                 retire_valid_i,
  input rv_core_pkg::retire_t retire_i
);

  logic        outstanding_q; // access started, done not yet seen.
  logic [31:0] retired_q;     // retirements since reset.

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 1'b0;
      retired_q     <= 32'd0;
    end else begin
      if (mem_valid_i) begin
        outstanding_q <= 1'b1;
      end else if (mem_done_i) begin
        outstanding_q <= 1'b0;
      end
      if (retire_valid_i) begin
        retired_q <= retired_q + 32'd1;
      end
    end
  end

  start_is_pulse: assert property (@(posedge clock) disable iff (!rst_n_i)
    mem_valid_i |=> !mem_valid_i)
    else $error("mem_valid_o held for more than one cycle");

  one_access: assert property (@(posedge clock) disable iff (!rst_n_i)
    outstanding_q |-> !mem_valid_i)
    else $error("mem_valid_o while an access is outstanding");

  order_step: assert property (@(posedge clock) disable iff (!rst_n_i)
    retire_valid_i |-> (retire_i.order == retired_q))
    else $error("retire order %0d does not follow %0d", retire_i.order, retired_q);

  quiet_in_reset: assert property (@(negedge clock)
    !rst_n_i |-> (!imem_valid_i && !mem_valid_i && !retire_valid_i))
    else $error("control output high during reset");

endmodule

bind core_top core_top_assert core_top_assert_i (
  .clock          (clock),
  .rst_n_i        (rst_n_i),
  .imem_valid_i   (imem_valid_o),
  .mem_valid_i    (mem_valid_o),
  .mem_done_i     (mem_done_i),
  .retire_valid_i (retire_valid_o),
  .retire_i       (retire_o)
);

//--- tb/core_top_tb.sv
`timescale 1ns/1ps

module core_top_tb;

  localparam int          QUEUE_DEPTH = 4;
  localparam logic [31:0] RESET_PC    = 32'h0000_0080;
  localparam int          MEM_WORDS   = 64;
  localparam int          PROG_BASE   = 8;  // word offsets in the golden image.
  localparam int          DATA_BASE   = 32;
  localparam int          REC_BASE    = 64;
  localparam int          WAIT_LIMIT  = 200;

  logic                  clock        = 1'b0;
  logic                  rst_n_i      = 1'b0;
  rv_core_pkg::insn_t    imem_rdata_i = '0;
  logic                  mem_done_i   = 1'b0;
  logic [31:0]           mem_rdata_i  = 32'd0;
  logic                  imem_valid_o;
  logic [31:0]           imem_addr_o;
  logic                  mem_valid_o;
  rv_core_pkg::mem_req_t mem_req_o;
  logic                  retire_valid_o;
  rv_core_pkg::retire_t  retire_o;

  logic [31:0] golden [256];
  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];
  logic [31:0] gold_regs [32]; // register values implied by the golden records.
  logic [31:0] lcg_state    = 32'hbb4a;
  int          value_errors = 0;
  int          other_errors = 0;

  core_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .RESET_PC    (RESET_PC)
  ) core_top_i (
    .clock          (clock),
    .rst_n_i        (rst_n_i),
    .imem_rdata_i   (imem_rdata_i),
    .mem_done_i     (mem_done_i),
    .mem_rdata_i    (mem_rdata_i),
    .imem_valid_o   (imem_valid_o),
    .imem_addr_o    (imem_addr_o),
    .mem_valid_o    (mem_valid_o),
    .mem_req_o      (mem_req_o),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  initial begin
    forever #10 clock = ~clock;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr >> 2) % 32'(MEM_WORDS));
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  // instruction memory answers one edge after the request
  logic        imem_pend      = 1'b0;
  logic [31:0] imem_pend_addr = 32'd0;

  always @(negedge clock) begin
    if (imem_pend) begin
      imem_rdata_i = imem[word_index(imem_pend_addr - RESET_PC)];
    end
    imem_pend      = (imem_valid_o === 1'b1);
    imem_pend_addr = imem_addr_o;
  end

  // data memory with a random 1 to 5 cycle completion
  logic                  dmem_busy = 1'b0;
  int                    dmem_wait = 0;
  rv_core_pkg::mem_req_t dmem_req  = '0;

  always @(negedge clock) begin
    mem_done_i = 1'b0;
    if (dmem_busy) begin
      dmem_wait = dmem_wait - 1;
      if (dmem_wait == 0) begin
        mem_done_i = 1'b1;
        dmem_busy  = 1'b0;
        if (dmem_req.wen) begin
          dmem[word_index(dmem_req.addr)] = dmem_req.wdata;
        end else begin
          mem_rdata_i = dmem[word_index(dmem_req.addr)];
        end
      end
    end
    if (mem_valid_o === 1'b1) begin
      compare("mem_req_o.strb", 32'(mem_req_o.strb), 32'h0000_000f);
      dmem_req  = mem_req_o;
      dmem_busy = 1'b1;
      lcg_state = lcg_next(lcg_state);
      dmem_wait = 1 + int'(lcg_state[23:16] % 8'd5);
    end
  end

  task automatic check_record(input int n);
    int          base;
    logic [31:0] exp_pc;
    logic [31:0] word;
    logic        no_trap;
    logic [3:0]  rmask;
    logic [3:0]  wmask;
    logic [31:0] exp_wdata;
    base      = REC_BASE + 5 * n;
    exp_pc    = RESET_PC + 32'(4 * n);    // no branches, so pc follows order.
    word      = imem[word_index(exp_pc - RESET_PC)];
    no_trap   = (golden[base + 4] == 32'd0);
    rmask     = (no_trap && word[6:0] == rv_core_pkg::OPC_LOAD) ? 4'hf : 4'h0;
    wmask     = (no_trap && word[6:0] == rv_core_pkg::OPC_STORE) ? 4'hf : 4'h0;
    exp_wdata = (wmask != 4'h0) ? gold_regs[word[24:20]] : 32'd0; // store data is rs2.
    compare("order", retire_o.order, golden[base]);
    compare("rd_addr", 32'(retire_o.rd_addr), golden[base + 1]);
    compare("rd_wdata", retire_o.rd_wdata, golden[base + 2]);
    compare("mem_addr", retire_o.mem_addr, golden[base + 3]);
    compare("trap", 32'(retire_o.trap), golden[base + 4]);
    compare("insn", retire_o.insn, word);
    compare("pc_rdata", retire_o.pc_rdata, exp_pc);
    compare("pc_wdata", retire_o.pc_wdata, exp_pc + 32'd4);
    compare("mem_rmask", 32'(retire_o.mem_rmask), 32'(rmask));
    compare("mem_wmask", 32'(retire_o.mem_wmask), 32'(wmask));
    compare("mem_wdata", retire_o.mem_wdata, exp_wdata);
    if (rmask != 4'h0) begin
      compare("mem_rdata", retire_o.mem_rdata, golden[base + 2]);
    end
    if (golden[base + 1] != 32'd0) begin
      gold_regs[golden[base + 1][4:0]] = golden[base + 2];
    end
  endtask

  initial begin
    int   prog_len;
    int   data_at;
    int   data_len;
    int   rec_count;
    int   waited;
    int   checked;
    logic timed_out;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = {12'(i), 13'd0, 7'b0010011}; // addi x0, x0, i past the program.
      dmem[i] = 32'hd0d0_0000 + 32'(i * 4);
    end
    for (int i = 0; i < 32; i++) begin
      gold_regs[i] = 32'd0;
    end
    $readmemh("tb/core_golden.txt", golden);
    prog_len  = int'(golden[0]);
    data_at   = word_index(golden[1]);
    data_len  = int'(golden[2]);
    rec_count = int'(golden[3]);
    for (int i = 0; i < prog_len; i++) begin
      imem[i] = golden[PROG_BASE + i];
    end
    for (int i = 0; i < data_len; i++) begin
      dmem[data_at + i] = golden[DATA_BASE + i];
    end

    repeat (16) @(negedge clock);
    rst_n_i = 1'b1;

    checked   = 0;
    timed_out = 1'b0;
    for (int n = 0; n < rec_count && !timed_out; n++) begin
      waited = 0;
      do begin
        @(negedge clock);
        waited++;
      end while (retire_valid_o !== 1'b1 && waited < WAIT_LIMIT);
      if (retire_valid_o !== 1'b1) begin
        $display("timeout: retirement %0d not seen within %0d cycles", n, WAIT_LIMIT);
        other_errors++;
        timed_out = 1'b1;
      end else begin
        check_record(n);
        checked++;
      end
    end

    $display("retirements checked %0d, value mismatches %0d, other failures %0d",
             checked, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
logic/rv_core_pkg.sv
logic/fetch_unit.sv
logic/insn_queue.sv
logic/exec_unit.sv
logic/core_top.sv
tb/core_top_assert.sv
tb/core_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds core_top_tb with verilator, runs it and scans the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module core_top_tb --Mdir obj_dir -o core_top_tb_sim -f list.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/core_top_tb_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Simulation finished: PASS" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- tb/core_golden.txt
// core_top_tb image for $readmemh, 32-bit hex words
// @00 program words, data base address, data words, records; @08 program; @20 data
// @40 records, one per line: order rd_addr rd_wdata mem_addr trap
@00
0000000e 00000040 00000004 0000000e
@08
00500093 ffd00113 123451b7 00700013
00208233 404182b3 04000313 00532423
00832383 00032403 ffffffff 008384b3
001f8533 00432583
@20
00000100 cafe0000 11111111 22222222
@40
00000000 00000001 00000005 00000000 00000000
00000001 00000002 fffffffd 00000000 00000000
00000002 00000003 12345000 00000000 00000000
00000003 00000000 00000000 00000000 00000000
00000004 00000004 00000002 00000000 00000000
00000005 00000005 12344ffe 00000000 00000000
00000006 00000006 00000040 00000000 00000000
00000007 00000000 00000000 00000048 00000000
00000008 00000007 12344ffe 00000048 00000000
00000009 00000008 00000100 00000040 00000000
0000000a 00000000 00000000 00000000 00000001
0000000b 00000009 123450fe 00000000 00000000
0000000c 0000000a 00000005 00000000 00000000
0000000d 0000000b cafe0000 00000044 00000000
